// ==== rd_xbar.f ====
logic/xbar_pkg.sv
logic/rd_chan_if.sv
logic/addr_decoder.sv
logic/rd_demux.sv
logic/decerr_responder.sv
logic/rd_mux.sv
logic/rd_xbar.sv
verification/clk_gen.sv
verification/tb_mem_slave.sv
verification/tb_rd_xbar.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the read crossbar testbench with Verilator and runs it into sim.log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --assert --top-module tb_rd_xbar -f rd_xbar.f

# The run result is taken from the log
./obj_dir/Vtb_rd_xbar > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q "sim passed" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation finished cleanly"

// ==== verification/tb_rd_xbar.sv ====
/*
  Random read traffic on every initiator port, checked beat by beat against
  an in-order model per initiator. Inputs change on the falling edge and all
  handshakes are sampled 2 ns later, where they hold until the rising edge.
*/
module tb_rd_xbar import xbar_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] SEED    = 32'h5e36_0271;
  localparam int          N_TRANS = 400;
  localparam int          TIMEOUT = 2000;  // Cycles

  typedef struct packed {
    logic [ID_IN_W-1:0] id;
    logic [SEL_W-1:0]   tgt;  // NUM_TGT for decode error
    logic [ADDR_W-1:0]  addr;
    logic [LEN_W-1:0]   len;
  } burst_t;

  logic                              clk_i;
  logic                              rst_n_i;
  logic [NUM_INIT-1:0][ID_IN_W-1:0]  ar_id_i;
  logic [NUM_INIT-1:0][ADDR_W-1:0]   ar_addr_i;
  logic [NUM_INIT-1:0][LEN_W-1:0]    ar_len_i;
  logic [NUM_INIT-1:0]               ar_valid_i;
  logic [NUM_INIT-1:0]               ar_ready_o;
  logic [NUM_INIT-1:0][ID_IN_W-1:0]  r_id_o;
  logic [NUM_INIT-1:0][DATA_W-1:0]   r_data_o;
  resp_e [NUM_INIT-1:0]              r_resp_o;
  logic [NUM_INIT-1:0]               r_last_o;
  logic [NUM_INIT-1:0]               r_valid_o;
  logic [NUM_INIT-1:0]               r_ready_i;
  logic [NUM_TGT-1:0][ID_OUT_W-1:0]  tgt_ar_id_o;
  logic [NUM_TGT-1:0][ADDR_W-1:0]    tgt_ar_addr_o;
  logic [NUM_TGT-1:0][LEN_W-1:0]     tgt_ar_len_o;
  logic [NUM_TGT-1:0]                tgt_ar_valid_o;
  logic [NUM_TGT-1:0]                tgt_ar_ready_i;
  logic [NUM_TGT-1:0][ID_OUT_W-1:0]  tgt_r_id_i;
  logic [NUM_TGT-1:0][DATA_W-1:0]    tgt_r_data_i;
  resp_e [NUM_TGT-1:0]               tgt_r_resp_i;
  logic [NUM_TGT-1:0]                tgt_r_last_i;
  logic [NUM_TGT-1:0]                tgt_r_valid_i;
  logic [NUM_TGT-1:0]                tgt_r_ready_o;

  burst_t              exp_q [NUM_INIT][$];  // Expected bursts in issue order
  int                  beat_idx [NUM_INIT];
  int                  sent [NUM_INIT];
  int                  quota [NUM_INIT];
  logic [NUM_INIT-1:0] ar_hs;
  int                  mode;  // 0 any address, 1 one target, 2 rotate regions
  int                  mode_tgt;

  clk_gen u_clk (
    .clk_o   (clk_i),
    .rst_n_o (rst_n_i)
  );

  rd_xbar DUT (.*);

  for (genvar t = 0; t < NUM_TGT; t++) begin : gen_mem
    tb_mem_slave #(.TGT_IDX(t)) u_mem (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .ar_id_i    (tgt_ar_id_o[t]),
      .ar_addr_i  (tgt_ar_addr_o[t]),
      .ar_len_i   (tgt_ar_len_o[t]),
      .ar_valid_i (tgt_ar_valid_o[t]),
      .ar_ready_o (tgt_ar_ready_i[t]),
      .r_id_o     (tgt_r_id_i[t]),
      .r_data_o   (tgt_r_data_i[t]),
      .r_resp_o   (tgt_r_resp_i[t]),
      .r_last_o   (tgt_r_last_i[t]),
      .r_valid_o  (tgt_r_valid_i[t]),
      .r_ready_i  (tgt_r_ready_o[t])
    );
  end

  task automatic stop_run(string what);
    $display("%s", what);
    $display("sim failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_data(string name, logic [DATA_W-1:0] exp_v, logic [DATA_W-1:0] act_v);
    if (act_v !== exp_v) begin
      stop_run($sformatf("Error at %0t: %s expected 'h%h, got 'h%h", $time, name, exp_v, act_v));
    end
  endtask

  task automatic check_resp(string name, resp_e exp_v, resp_e act_v);
    if (act_v !== exp_v) begin
      stop_run($sformatf("Error at %0t: %s expected %0d, got %0d", $time, name, exp_v, act_v));
    end
  endtask

  task automatic check_id(string name, logic [ID_IN_W-1:0] exp_v, logic [ID_IN_W-1:0] act_v);
    if (act_v !== exp_v) begin
      stop_run($sformatf("Error at %0t: %s expected %0d, got %0d", $time, name, exp_v, act_v));
    end
  endtask

  task automatic check_len(string name, logic [LEN_W-1:0] exp_v, logic [LEN_W-1:0] act_v);
    if (act_v !== exp_v) begin
      stop_run($sformatf("Error at %0t: %s expected %0d, got %0d", $time, name, exp_v, act_v));
    end
  endtask

  task automatic check_last(string name, logic exp_v, logic act_v);
    if (act_v !== exp_v) begin
      stop_run($sformatf("Error at %0t: %s expected %b, got %b", $time, name, exp_v, act_v));
    end
  endtask

  task automatic check_valid(string name, logic exp_v, logic act_v);
    if (act_v !== exp_v) begin
      stop_run($sformatf("Error at %0t: %s expected %b, got %b", $time, name, exp_v, act_v));
    end
  endtask

  // Target index from the address map or NUM_TGT when nothing matches
  function automatic int decode_ref(logic [ADDR_W-1:0] addr);
    int sel;
    sel = NUM_TGT;
    for (int t = 0; t < NUM_TGT; t++) begin
      if ((addr >= TGT_BASE[t]) && (addr <= TGT_END[t])) begin
        sel = t;
      end
    end
    return sel;
  endfunction

  function automatic logic [DATA_W-1:0] expected_data(burst_t b, int beat);
    logic [ADDR_W-1:0] a;
    a = b.addr + ADDR_W'(beat);
    if (b.tgt == SEL_W'(NUM_TGT)) begin
      return '0;
    end
    return {8'(b.tgt), 8'h00, a};
  endfunction

  function automatic logic [ADDR_W-1:0] pick_addr(int i);
    int                region;
    logic [ADDR_W-1:0] span;
    if (mode == 0) begin
      return ADDR_W'($urandom);
    end
    region = (mode == 1) ? mode_tgt : (sent[i] % (NUM_TGT + 1));
    if (region == NUM_TGT) begin
      return 16'h8000 | ADDR_W'($urandom % 32'h8000);  // Unmapped upper half
    end
    span = TGT_END[region] - TGT_BASE[region];
    return TGT_BASE[region] + ADDR_W'($urandom % (int'(span) + 1));
  endfunction

  function automatic logic queues_empty();
    for (int i = 0; i < NUM_INIT; i++) begin
      if (exp_q[i].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic drive_inputs();
    for (int i = 0; i < NUM_INIT; i++) begin
      if (ar_hs[i]) begin
        ar_valid_i[i] = 1'b0;
      end
      if (!ar_valid_i[i] && (sent[i] < quota[i]) && (($urandom % 4) != 0)) begin
        ar_id_i[i]    = ID_IN_W'($urandom);
        ar_addr_i[i]  = pick_addr(i);
        ar_len_i[i]   = LEN_W'($urandom);
        ar_valid_i[i] = 1'b1;
      end
      r_ready_i[i] = ($urandom % 4) != 0;  // Random back-pressure
    end
  endtask

  task automatic sample_cycle(output logic progress);
    burst_t b;
    resp_e  exp_resp;
    int     k;
    progress = 1'b0;
    for (int t = 0; t < NUM_TGT; t++) begin
      if (tgt_ar_valid_o[t] && (decode_ref(tgt_ar_addr_o[t]) != t)) begin
        stop_run($sformatf("Target %0d was offered address 'h%h outside its range",
                           t, tgt_ar_addr_o[t]));
      end
      if (tgt_ar_valid_o[t] && tgt_ar_ready_i[t]) begin
        k = int'(tgt_ar_id_o[t][ID_OUT_W-1 -: INIT_IDX_W]);
        if ((k >= NUM_INIT) || !(ar_valid_i[k] && ar_ready_o[k]) ||
            (tgt_ar_addr_o[t] !== ar_addr_i[k])) begin
          stop_run($sformatf("Target %0d took a request whose ID prefix %0d is wrong", t, k));
        end
        check_id($sformatf("tgt_ar_id_o[%0d] low bits", t), ar_id_i[k],
                 tgt_ar_id_o[t][ID_IN_W-1:0]);
        check_len($sformatf("tgt_ar_len_o[%0d]", t), ar_len_i[k], tgt_ar_len_o[t]);
      end
    end
    for (int i = 0; i < NUM_INIT; i++) begin
      if (r_valid_o[i] && r_ready_i[i]) begin
        if (exp_q[i].size() == 0) begin
          stop_run($sformatf("Initiator %0d got an R beat with no read outstanding", i));
        end
        b = exp_q[i][0];
        if (b.tgt == SEL_W'(NUM_TGT)) begin
          exp_resp = RESP_DECERR;
        end else begin
          exp_resp = RESP_OKAY;
        end
        check_id($sformatf("r_id_o[%0d]", i), b.id, r_id_o[i]);
        check_resp($sformatf("r_resp_o[%0d]", i), exp_resp, r_resp_o[i]);
        check_data($sformatf("r_data_o[%0d]", i), expected_data(b, beat_idx[i]), r_data_o[i]);
        check_last($sformatf("r_last_o[%0d]", i), beat_idx[i] == int'(b.len), r_last_o[i]);
        if (r_last_o[i]) begin
          void'(exp_q[i].pop_front());
          beat_idx[i] = 0;
        end else begin
          beat_idx[i]++;
        end
        progress = 1'b1;
      end
      ar_hs[i] = ar_valid_i[i] && ar_ready_o[i];
      if (ar_hs[i]) begin
        b.id   = ar_id_i[i];
        b.tgt  = SEL_W'(decode_ref(ar_addr_i[i]));
        b.addr = ar_addr_i[i];
        b.len  = ar_len_i[i];
        exp_q[i].push_back(b);
        sent[i]++;
        progress = 1'b1;
      end
    end
  endtask

  task automatic step_cycle(output logic progress);
    @(negedge clk_i);
    drive_inputs();
    #2;
    sample_cycle(progress);
  endtask

  // Initiator 0 issues n_first reads and every other initiator n_rest
  task automatic run_phase(int m, int t, int n_first, int n_rest);
    int   idle;
    logic progress;
    logic pending;
    mode     = m;
    mode_tgt = t;
    for (int i = 0; i < NUM_INIT; i++) begin
      quota[i] = sent[i] + ((i == 0) ? n_first : n_rest);
    end
    idle    = 0;
    pending = 1'b1;
    while (pending) begin
      step_cycle(progress);
      idle = progress ? 0 : idle + 1;
      if (idle > TIMEOUT) begin
        stop_run("Timed out waiting for a read request or beat to be accepted");
      end
      pending = 1'b0;
      for (int i = 0; i < NUM_INIT; i++) begin
        if (sent[i] < quota[i]) begin
          pending = 1'b1;
        end
      end
    end
  endtask

  initial begin : main
    int   wait_cnt;
    logic progress;
    void'($urandom(SEED));
    ar_id_i    = '0;
    ar_addr_i  = '0;
    ar_len_i   = '0;
    ar_valid_i = '0;
    r_ready_i  = '0;
    ar_hs      = '0;
    mode       = 0;
    mode_tgt   = 0;
    for (int i = 0; i < NUM_INIT; i++) begin
      beat_idx[i] = 0;
      sent[i]     = 0;
      quota[i]    = 0;
    end

    wait_cnt = 0;
    while (rst_n_i !== 1'b1) begin
      @(negedge clk_i);
      wait_cnt++;
      if (wait_cnt > TIMEOUT) begin
        stop_run("Timed out waiting for reset to be released");
      end
    end
    #2;
    for (int t = 0; t < NUM_TGT; t++) begin
      check_valid($sformatf("tgt_ar_valid_o[%0d]", t), 1'b0, tgt_ar_valid_o[t]);
    end
    for (int i = 0; i < NUM_INIT; i++) begin
      check_valid($sformatf("r_valid_o[%0d]", i), 1'b0, r_valid_o[i]);
    end

    run_phase(0, 0, N_TRANS / 4, N_TRANS / 4);  // Whole address range
    for (int t = 0; t < NUM_TGT; t++) begin
      run_phase(1, t, N_TRANS / 16, N_TRANS / 16);  // Both initiators on one target
    end
    run_phase(2, 0, N_TRANS / 4, 0);

    wait_cnt = 0;
    while (!queues_empty()) begin
      step_cycle(progress);
      wait_cnt++;
      if (wait_cnt > TIMEOUT) begin
        stop_run("Timed out waiting for the outstanding reads to complete");
      end
    end

    $display("sim passed");
    $finish;
  end

endmodule

// ==== verification/tb_mem_slave.sv ====
/*
  Behavioral in-order target with random ar_ready and gaps in r_valid.
  Beat k of a burst carries TGT_IDX in bits 31:24 and ar_addr+k in bits 15:0.
  Outputs change on the falling edge only.
*/
module tb_mem_slave import xbar_pkg::*; #(
  parameter int TGT_IDX = 0
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic [ID_OUT_W-1:0] ar_id_i,
  input  logic [ADDR_W-1:0]   ar_addr_i,
  input  logic [LEN_W-1:0]    ar_len_i,
  input  logic                ar_valid_i,
  output logic                ar_ready_o,
  output logic [ID_OUT_W-1:0] r_id_o,
  output logic [DATA_W-1:0]   r_data_o,
  output resp_e               r_resp_o,
  output logic                r_last_o,
  output logic                r_valid_o,
  input  logic                r_ready_i
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [ID_OUT_W-1:0] id_q [$];
  logic [ADDR_W-1:0]   addr_q [$];
  logic [LEN_W-1:0]    len_q [$];
  int                  beat;
  logic                r_hs;

  initial begin : serve
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_id_o     = '0;
    r_data_o   = '0;
    r_resp_o   = RESP_OKAY;
    r_last_o   = 1'b0;
    beat       = 0;
    r_hs       = 1'b0;
    forever begin
      @(negedge clk_i);
      if (rst_n_i) begin
        ar_ready_o = ($urandom % 3) != 0;
        // A beat on the bus stays until it is taken
        if (!r_valid_o || r_hs) begin
          r_valid_o = (id_q.size() > 0) && (($urandom % 3) != 0);
          if (r_valid_o) begin
            r_id_o   = id_q[0];
            r_data_o = {8'(TGT_IDX), 8'h00, ADDR_W'(addr_q[0] + ADDR_W'(beat))};
            r_resp_o = RESP_OKAY;
            r_last_o = (beat == int'(len_q[0]));
          end
        end
      end
      #2;  // Inputs have settled for the coming rising edge
      r_hs = r_valid_o && r_ready_i;
      if (r_hs) begin
        if (r_last_o) begin
          void'(id_q.pop_front());
          void'(addr_q.pop_front());
          void'(len_q.pop_front());
          beat = 0;
        end else begin
          beat++;
        end
      end
      if (ar_valid_i && ar_ready_o) begin
        id_q.push_back(ar_id_i);
        addr_q.push_back(ar_addr_i);
        len_q.push_back(ar_len_i);
      end
    end
  end

endmodule

// ==== verification/clk_gen.sv ====
/*
  Free-running 8 ns clock for the testbench.
  Reset is held low for the first 5 cycles and released on a falling edge.
*/
module clk_gen (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;  // Half period
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// ==== logic/rd_xbar.sv ====
/*
  Read-only crossbar, NUM_INIT initiators to NUM_TGT targets.
  Target IDs are ID_OUT_W wide, with the initiator index in the top bits.
  Targets must return R beats in order per ID prefix.
*/
module rd_xbar import xbar_pkg::*; (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // Initiator ports
  input  logic [NUM_INIT-1:0][ID_IN_W-1:0]  ar_id_i,
  input  logic [NUM_INIT-1:0][ADDR_W-1:0]   ar_addr_i,
  input  logic [NUM_INIT-1:0][LEN_W-1:0]    ar_len_i,
  input  logic [NUM_INIT-1:0]               ar_valid_i,
  output logic [NUM_INIT-1:0]               ar_ready_o,
  output logic [NUM_INIT-1:0][ID_IN_W-1:0]  r_id_o,
  output logic [NUM_INIT-1:0][DATA_W-1:0]   r_data_o,
  output resp_e [NUM_INIT-1:0]              r_resp_o,
  output logic [NUM_INIT-1:0]               r_last_o,
  output logic [NUM_INIT-1:0]               r_valid_o,
  input  logic [NUM_INIT-1:0]               r_ready_i,
  // Target ports
  output logic [NUM_TGT-1:0][ID_OUT_W-1:0]  tgt_ar_id_o,
  output logic [NUM_TGT-1:0][ADDR_W-1:0]    tgt_ar_addr_o,
  output logic [NUM_TGT-1:0][LEN_W-1:0]     tgt_ar_len_o,
  output logic [NUM_TGT-1:0]                tgt_ar_valid_o,
  input  logic [NUM_TGT-1:0]                tgt_ar_ready_i,
  input  logic [NUM_TGT-1:0][ID_OUT_W-1:0]  tgt_r_id_i,
  input  logic [NUM_TGT-1:0][DATA_W-1:0]    tgt_r_data_i,
  input  resp_e [NUM_TGT-1:0]               tgt_r_resp_i,
  input  logic [NUM_TGT-1:0]                tgt_r_last_i,
  input  logic [NUM_TGT-1:0]                tgt_r_valid_i,
  output logic [NUM_TGT-1:0]                tgt_r_ready_o
);

  // Demux side, initiator-major
  logic [NUM_INIT-1:0][NUM_TGT-1:0][ID_IN_W-1:0] dm_ar_id;
  logic [NUM_INIT-1:0][NUM_TGT-1:0][ADDR_W-1:0]  dm_ar_addr;
  logic [NUM_INIT-1:0][NUM_TGT-1:0][LEN_W-1:0]   dm_ar_len;
  logic [NUM_INIT-1:0][NUM_TGT-1:0]              dm_ar_valid;
  logic [NUM_INIT-1:0][NUM_TGT-1:0]              dm_ar_ready;
  logic [NUM_INIT-1:0][NUM_TGT-1:0][ID_IN_W-1:0] dm_r_id;
  logic [NUM_INIT-1:0][NUM_TGT-1:0][DATA_W-1:0]  dm_r_data;
  resp_e [NUM_INIT-1:0][NUM_TGT-1:0]             dm_r_resp;
  logic [NUM_INIT-1:0][NUM_TGT-1:0]              dm_r_last;
  logic [NUM_INIT-1:0][NUM_TGT-1:0]              dm_r_valid;
  logic [NUM_INIT-1:0][NUM_TGT-1:0]              dm_r_ready;

  // Mux side, target-major
  logic [NUM_TGT-1:0][NUM_INIT-1:0][ID_IN_W-1:0] mx_ar_id;
  logic [NUM_TGT-1:0][NUM_INIT-1:0][ADDR_W-1:0]  mx_ar_addr;
  logic [NUM_TGT-1:0][NUM_INIT-1:0][LEN_W-1:0]   mx_ar_len;
  logic [NUM_TGT-1:0][NUM_INIT-1:0]              mx_ar_valid;
  logic [NUM_TGT-1:0][NUM_INIT-1:0]              mx_ar_ready;
  logic [NUM_TGT-1:0][NUM_INIT-1:0][ID_IN_W-1:0] mx_r_id;
  logic [NUM_TGT-1:0][NUM_INIT-1:0][DATA_W-1:0]  mx_r_data;
  resp_e [NUM_TGT-1:0][NUM_INIT-1:0]             mx_r_resp;
  logic [NUM_TGT-1:0][NUM_INIT-1:0]              mx_r_last;
  logic [NUM_TGT-1:0][NUM_INIT-1:0]              mx_r_valid;
  logic [NUM_TGT-1:0][NUM_INIT-1:0]              mx_r_ready;

  for (genvar i = 0; i < NUM_INIT; i++) begin : gen_init
    rd_chan_if u_de_if ();

    rd_demux u_demux (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .s_ar_id_i    (ar_id_i[i]),
      .s_ar_addr_i  (ar_addr_i[i]),
      .s_ar_len_i   (ar_len_i[i]),
      .s_ar_valid_i (ar_valid_i[i]),
      .s_ar_ready_o (ar_ready_o[i]),
      .s_r_id_o     (r_id_o[i]),
      .s_r_data_o   (r_data_o[i]),
      .s_r_resp_o   (r_resp_o[i]),
      .s_r_last_o   (r_last_o[i]),
      .s_r_valid_o  (r_valid_o[i]),
      .s_r_ready_i  (r_ready_i[i]),
      .m_ar_id_o    (dm_ar_id[i]),
      .m_ar_addr_o  (dm_ar_addr[i]),
      .m_ar_len_o   (dm_ar_len[i]),
      .m_ar_valid_o (dm_ar_valid[i]),
      .m_ar_ready_i (dm_ar_ready[i]),
      .m_r_id_i     (dm_r_id[i]),
      .m_r_data_i   (dm_r_data[i]),
      .m_r_resp_i   (dm_r_resp[i]),
      .m_r_last_i   (dm_r_last[i]),
      .m_r_valid_i  (dm_r_valid[i]),
      .m_r_ready_o  (dm_r_ready[i]),
      .decerr_if    (u_de_if)
    );

    decerr_responder u_decerr (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .chan    (u_de_if)
    );

    for (genvar t = 0; t < NUM_TGT; t++) begin : gen_cross
      assign mx_ar_id[t][i]    = dm_ar_id[i][t];
      assign mx_ar_addr[t][i]  = dm_ar_addr[i][t];
      assign mx_ar_len[t][i]   = dm_ar_len[i][t];
      assign mx_ar_valid[t][i] = dm_ar_valid[i][t];
      assign dm_ar_ready[i][t] = mx_ar_ready[t][i];
      assign dm_r_id[i][t]     = mx_r_id[t][i];
      assign dm_r_data[i][t]   = mx_r_data[t][i];
      assign dm_r_resp[i][t]   = mx_r_resp[t][i];
      assign dm_r_last[i][t]   = mx_r_last[t][i];
      assign dm_r_valid[i][t]  = mx_r_valid[t][i];
      assign mx_r_ready[t][i]  = dm_r_ready[i][t];
    end
  end

  for (genvar t = 0; t < NUM_TGT; t++) begin : gen_tgt
    rd_mux u_mux (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .s_ar_id_i    (mx_ar_id[t]),
      .s_ar_addr_i  (mx_ar_addr[t]),
      .s_ar_len_i   (mx_ar_len[t]),
      .s_ar_valid_i (mx_ar_valid[t]),
      .s_ar_ready_o (mx_ar_ready[t]),
      .s_r_id_o     (mx_r_id[t]),
      .s_r_data_o   (mx_r_data[t]),
      .s_r_resp_o   (mx_r_resp[t]),
      .s_r_last_o   (mx_r_last[t]),
      .s_r_valid_o  (mx_r_valid[t]),
      .s_r_ready_i  (mx_r_ready[t]),
      .m_ar_id_o    (tgt_ar_id_o[t]),
      .m_ar_addr_o  (tgt_ar_addr_o[t]),
      .m_ar_len_o   (tgt_ar_len_o[t]),
      .m_ar_valid_o (tgt_ar_valid_o[t]),
      .m_ar_ready_i (tgt_ar_ready_i[t]),
      .m_r_id_i     (tgt_r_id_i[t]),
      .m_r_data_i   (tgt_r_data_i[t]),
      .m_r_resp_i   (tgt_r_resp_i[t]),
      .m_r_last_i   (tgt_r_last_i[t]),
      .m_r_valid_i  (tgt_r_valid_i[t]),
      .m_r_ready_o  (tgt_r_ready_o[t])
    );
  end

endmodule

// ==== logic/rd_mux.sv ====
/*
  Per-target AR arbiter with a registered round-robin grant.
  An idle grant takes one cycle to move to a new requester.
  The initiator index goes into the top ID bits and routes R beats back.
*/
module rd_mux import xbar_pkg::*; (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // Initiator side, one slice per initiator
  input  logic [NUM_INIT-1:0][ID_IN_W-1:0]  s_ar_id_i,
  input  logic [NUM_INIT-1:0][ADDR_W-1:0]   s_ar_addr_i,
  input  logic [NUM_INIT-1:0][LEN_W-1:0]    s_ar_len_i,
  input  logic [NUM_INIT-1:0]               s_ar_valid_i,
  output logic [NUM_INIT-1:0]               s_ar_ready_o,
  output logic [NUM_INIT-1:0][ID_IN_W-1:0]  s_r_id_o,
  output logic [NUM_INIT-1:0][DATA_W-1:0]   s_r_data_o,
  output resp_e [NUM_INIT-1:0]              s_r_resp_o,
  output logic [NUM_INIT-1:0]               s_r_last_o,
  output logic [NUM_INIT-1:0]               s_r_valid_o,
  input  logic [NUM_INIT-1:0]               s_r_ready_i,
  // Target port
  output logic [ID_OUT_W-1:0]               m_ar_id_o,
  output logic [ADDR_W-1:0]                 m_ar_addr_o,
  output logic [LEN_W-1:0]                  m_ar_len_o,
  output logic                              m_ar_valid_o,
  input  logic                              m_ar_ready_i,
  input  logic [ID_OUT_W-1:0]               m_r_id_i,
  input  logic [DATA_W-1:0]                 m_r_data_i,
  input  resp_e                             m_r_resp_i,
  input  logic                              m_r_last_i,
  input  logic                              m_r_valid_i,
  output logic                              m_r_ready_o
);

  logic [INIT_IDX_W-1:0] grant_q;
  logic [INIT_IDX_W-1:0] grant_d;
  logic [INIT_IDX_W-1:0] r_init;  // Owner of the current R beat
  logic                  hold;

  // Next requester after the current grant, current one last
  always_comb begin : rr_next
    logic found;
    int   cand;
    found   = 1'b0;
    grant_d = grant_q;
    for (int k = 1; k <= NUM_INIT; k++) begin
      cand = (int'(grant_q) + k) % NUM_INIT;
      if (!found && s_ar_valid_i[cand]) begin
        grant_d = INIT_IDX_W'(cand);
        found   = 1'b1;
      end
    end
  end

  assign hold = m_ar_valid_o && !m_ar_ready_i;  // Pending AR locks the grant

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      grant_q <= '0;
    end else if (!hold) begin
      grant_q <= grant_d;
    end
  end

  assign m_ar_valid_o = s_ar_valid_i[grant_q];
  assign m_ar_id_o    = {grant_q, s_ar_id_i[grant_q]};
  assign m_ar_addr_o  = s_ar_addr_i[grant_q];
  assign m_ar_len_o   = s_ar_len_i[grant_q];

  assign r_init      = m_r_id_i[ID_OUT_W-1 -: INIT_IDX_W];
  assign m_r_ready_o = s_r_ready_i[r_init];

  always_comb begin : fan_back
    for (int i = 0; i < NUM_INIT; i++) begin
      s_ar_ready_o[i] = m_ar_ready_i && (grant_q == INIT_IDX_W'(i));
      s_r_valid_o[i]  = m_r_valid_i && (r_init == INIT_IDX_W'(i));
      s_r_id_o[i]     = m_r_id_i[ID_IN_W-1:0];  // Prefix stripped
      s_r_data_o[i]   = m_r_data_i;
      s_r_resp_o[i]   = m_r_resp_i;
      s_r_last_o[i]   = m_r_last_i;
    end
  end

  a_ar_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (m_ar_valid_o && !m_ar_ready_i) |=> (m_ar_valid_o && $stable(m_ar_addr_o)))
    else $error("Target AR changed before it was accepted");

endmodule

// ==== logic/decerr_responder.sv ====
/*
  Fake target for unmapped addresses. Serves one burst at a time and
  answers it with len+1 beats of zero data and DECERR.
*/
module decerr_responder import xbar_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  rd_chan_if.target chan
);

  decerr_state_e      state;
  logic [ID_IN_W-1:0] id_q;
  logic [LEN_W-1:0]   len_q;
  logic [LEN_W-1:0]   beat_q;  // Index of the beat on the bus

  assign chan.ar_ready = (state == DE_IDLE);
  assign chan.r_valid  = (state == DE_BURST);
  assign chan.r_id     = id_q;
  assign chan.r_data   = '0;
  assign chan.r_resp   = RESP_DECERR;
  assign chan.r_last   = (beat_q == len_q);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state  <= DE_IDLE;
      beat_q <= '0;
    end else begin
      case (state)
        DE_IDLE: begin
          if (chan.ar_valid) begin
            state  <= DE_BURST;
            beat_q <= '0;
          end
        end
        DE_BURST: begin
          if (chan.r_ready) begin
            beat_q <= beat_q + LEN_W'(1);
            if (chan.r_last) begin
              state <= DE_IDLE;  // ar_ready again next cycle
            end
          end
        end
        default: state <= DE_IDLE;
      endcase
    end
  end

  // Request fields kept for the whole burst
  always_ff @(posedge clk_i) begin
    if (chan.ar_valid && chan.ar_ready) begin
      id_q  <= chan.ar_id;
      len_q <= chan.ar_len;
    end
  end

  a_r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (chan.r_valid && !chan.r_ready) |=> (chan.r_valid && $stable(chan.r_id)))
    else $error("Error beat dropped before it was accepted");

endmodule

// ==== logic/rd_demux.sv ====
/*
  Per-initiator router. Every outstanding read of this port goes to one target,
  so R beats come back in issue order without per-ID tracking.
  An AR to another target waits until the outstanding count drains to zero.
*/
module rd_demux import xbar_pkg::*; (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // Initiator port
  input  logic [ID_IN_W-1:0]                s_ar_id_i,
  input  logic [ADDR_W-1:0]                 s_ar_addr_i,
  input  logic [LEN_W-1:0]                  s_ar_len_i,
  input  logic                              s_ar_valid_i,
  output logic                              s_ar_ready_o,
  output logic [ID_IN_W-1:0]                s_r_id_o,
  output logic [DATA_W-1:0]                 s_r_data_o,
  output resp_e                             s_r_resp_o,
  output logic                              s_r_last_o,
  output logic                              s_r_valid_o,
  input  logic                              s_r_ready_i,
  // Target side, one slice per target
  output logic [NUM_TGT-1:0][ID_IN_W-1:0]   m_ar_id_o,
  output logic [NUM_TGT-1:0][ADDR_W-1:0]    m_ar_addr_o,
  output logic [NUM_TGT-1:0][LEN_W-1:0]     m_ar_len_o,
  output logic [NUM_TGT-1:0]                m_ar_valid_o,
  input  logic [NUM_TGT-1:0]                m_ar_ready_i,
  input  logic [NUM_TGT-1:0][ID_IN_W-1:0]   m_r_id_i,
  input  logic [NUM_TGT-1:0][DATA_W-1:0]    m_r_data_i,
  input  resp_e [NUM_TGT-1:0]               m_r_resp_i,
  input  logic [NUM_TGT-1:0]                m_r_last_i,
  input  logic [NUM_TGT-1:0]                m_r_valid_i,
  output logic [NUM_TGT-1:0]                m_r_ready_o,
  // Decode error responder
  rd_chan_if.initiator                      decerr_if
);

  logic [SEL_W-1:0] ar_sel;
  logic [SEL_W-1:0] cur_tgt;  // Target of all outstanding reads
  logic [CNT_W-1:0] cnt;
  logic             ar_stall;
  logic             sel_ready;
  logic             ar_hs;
  logic             r_done;

  addr_decoder u_dec (
    .addr_i (s_ar_addr_i),
    .sel_o  (ar_sel)
  );

  assign ar_stall = ((cnt != '0) && (ar_sel != cur_tgt)) || (cnt == CNT_W'(MAX_TRANS));

  // Payload fans out to every target, only valid is steered
  assign m_ar_id_o   = {NUM_TGT{s_ar_id_i}};
  assign m_ar_addr_o = {NUM_TGT{s_ar_addr_i}};
  assign m_ar_len_o  = {NUM_TGT{s_ar_len_i}};

  assign decerr_if.ar_id    = s_ar_id_i;
  assign decerr_if.ar_addr  = s_ar_addr_i;
  assign decerr_if.ar_len   = s_ar_len_i;
  assign decerr_if.ar_valid = s_ar_valid_i && !ar_stall && (ar_sel == SEL_W'(NUM_TGT));

  always_comb begin : ar_route
    sel_ready = decerr_if.ar_ready;
    for (int t = 0; t < NUM_TGT; t++) begin
      m_ar_valid_o[t] = s_ar_valid_i && !ar_stall && (ar_sel == SEL_W'(t));
      if (ar_sel == SEL_W'(t)) begin
        sel_ready = m_ar_ready_i[t];
      end
    end
  end

  assign s_ar_ready_o = !ar_stall && sel_ready;
  assign ar_hs        = s_ar_valid_i && s_ar_ready_o;

  // R only from the current target
  always_comb begin : r_route
    s_r_id_o          = decerr_if.r_id;
    s_r_data_o        = decerr_if.r_data;
    s_r_resp_o        = decerr_if.r_resp;
    s_r_last_o        = decerr_if.r_last;
    s_r_valid_o       = decerr_if.r_valid && (cur_tgt == SEL_W'(NUM_TGT));
    decerr_if.r_ready = s_r_ready_i && (cur_tgt == SEL_W'(NUM_TGT));
    for (int t = 0; t < NUM_TGT; t++) begin
      m_r_ready_o[t] = s_r_ready_i && (cur_tgt == SEL_W'(t));
      if (cur_tgt == SEL_W'(t)) begin
        s_r_id_o    = m_r_id_i[t];
        s_r_data_o  = m_r_data_i[t];
        s_r_resp_o  = m_r_resp_i[t];
        s_r_last_o  = m_r_last_i[t];
        s_r_valid_o = m_r_valid_i[t];
      end
    end
  end

  assign r_done = s_r_valid_o && s_r_ready_i && s_r_last_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt     <= '0;
      cur_tgt <= '0;
    end else begin
      if (ar_hs) begin
        cur_tgt <= ar_sel;
      end
      if (ar_hs && !r_done) begin
        cnt <= cnt + CNT_W'(1);
      end else if (!ar_hs && r_done) begin
        cnt <= cnt - CNT_W'(1);
      end
    end
  end

  a_cnt_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cnt <= CNT_W'(MAX_TRANS))
    else $error("Outstanding read count above MAX_TRANS");

endmodule

// ==== logic/addr_decoder.sv ====
/*
  Combinational lookup of an address in the fixed map.
  Gives NUM_TGT when no range matches, which routes to the error responder.
*/
module addr_decoder import xbar_pkg::*; (
  input  logic [ADDR_W-1:0] addr_i,
  output logic [SEL_W-1:0]  sel_o
);

  always_comb begin : map_lookup
    sel_o = SEL_W'(NUM_TGT);  // Decode error unless a range hits
    for (int t = 0; t < NUM_TGT; t++) begin
      if ((addr_i >= TGT_BASE[t]) && (addr_i <= TGT_END[t])) begin
        sel_o = SEL_W'(t);
      end
    end
  end

  // Map sanity, checked once at start
  initial begin : map_check
    for (int a = 0; a < NUM_TGT; a++) begin
      assert (TGT_BASE[a] <= TGT_END[a])
        else $error("Address map entry %0d has base above end", a);
      for (int b = a + 1; b < NUM_TGT; b++) begin
        assert ((TGT_END[a] < TGT_BASE[b]) || (TGT_END[b] < TGT_BASE[a]))
          else $error("Address map entries %0d and %0d overlap", a, b);
      end
    end
  end

endmodule

// ==== logic/rd_chan_if.sv ====
/*
  One AR and R channel pair with initiator side IDs.
  Used only on the link from a demux to its decode-error responder.
*/
interface rd_chan_if import xbar_pkg::*; ();

  logic [ID_IN_W-1:0] ar_id;
  logic [ADDR_W-1:0]  ar_addr;
  logic [LEN_W-1:0]   ar_len;
  logic               ar_valid;
  logic               ar_ready;

  logic [ID_IN_W-1:0] r_id;
  logic [DATA_W-1:0]  r_data;
  resp_e              r_resp;
  logic               r_last;
  logic               r_valid;
  logic               r_ready;

  modport initiator (
    output ar_id, ar_addr, ar_len, ar_valid, r_ready,
    input  ar_ready, r_id, r_data, r_resp, r_last, r_valid
  );

  modport target (
    input  ar_id, ar_addr, ar_len, ar_valid, r_ready,
    output ar_ready, r_id, r_data, r_resp, r_last, r_valid
  );

endinterface

// ==== logic/xbar_pkg.sv ====
/*
  Shared constants and types of the read-only crossbar.
  The address map is fixed at compile time and ranges must not overlap.
  Widths here are the only source for every port in the design.
*/
package xbar_pkg;

  localparam int NUM_INIT  = 2;
  localparam int NUM_TGT   = 2;

  localparam int ADDR_W    = 16;
  localparam int DATA_W    = 32;
  localparam int LEN_W     = 4;  // Burst has len+1 beats
  localparam int ID_IN_W   = 2;

  // Bits needed for an initiator index, at least one
  localparam int INIT_IDX_W = (NUM_INIT > 1) ? $clog2(NUM_INIT) : 1;
  localparam int ID_OUT_W   = ID_IN_W + INIT_IDX_W;

  // Select holds 0..NUM_TGT, NUM_TGT is the decode error port
  localparam int SEL_W     = $clog2(NUM_TGT + 1);

  localparam int MAX_TRANS = 4;
  localparam int CNT_W     = $clog2(MAX_TRANS + 1);

  // Inclusive ranges, entry 0 is the rightmost element
  localparam logic [NUM_TGT-1:0][ADDR_W-1:0] TGT_BASE = {16'h4000, 16'h0000};
  localparam logic [NUM_TGT-1:0][ADDR_W-1:0] TGT_END  = {16'h7FFF, 16'h3FFF};

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_DECERR = 2'd3
  } resp_e;

  typedef enum logic {
    DE_IDLE,  // Waiting for an AR
    DE_BURST  // Returning error beats
  } decerr_state_e;

endpackage
